// ==== acs/vit_3by4_dec_acs.sv ====
// Add-compare-select over 8 fully connected states; ties go to the lowest predecessor index
`timescale 1ns/1ns

module vit_3by4_dec_acs
  import vit_3by4_pkg::*;
(
  input  logic iclk,
  input  logic ireset,
  input  logic iclkena,
  //
  input  logic isop,
  input  logic ival,
  input  logic ieop,
  input  tag_t itag,
  input  bm_t  ibm,                // Metrics of all 16 labels
  //
  output logic osop,
  output logic oval,
  output logic oeop,
  output tag_t otag,
  output dec_t odec,               // Survivors of this step
  output pm_t  opm [cSTATE_NUM]    // Normalized metrics after this step
);

  // Far below any reachable metric, still clear of overflow
  localparam pm_t cPM_INIT = pm_t'(-256);

  pm_t  pm_pred [cSTATE_NUM];   // Predecessor metrics for this step
  pm_t  pm_new  [cSTATE_NUM];
  dec_t dec_new;

  //----------------------------------------------------------
  // Predecessor selection
  //----------------------------------------------------------

  // Encoder starts in state 0, so a frame start seeds from it alone
  always_comb begin
    for (int s = 0; s < cSTATE_NUM; s++) begin
      if (isop) begin
        pm_pred[s] = (s == 0) ? pm_t'(0) : cPM_INIT;
      end else begin
        pm_pred[s] = opm[s];
      end
    end
  end

  //----------------------------------------------------------
  // Add, compare, select
  //----------------------------------------------------------

  always_comb begin
    pm_t  cand;
    pm_t  best;
    sym_t sel;
    for (int u = 0; u < cSTATE_NUM; u++) begin
      best = pm_pred[0] + ibm[trel_label(sym_t'(0), sym_t'(u))];
      sel  = '0;
      for (int s = 1; s < cSTATE_NUM; s++) begin
        cand = pm_pred[s] + ibm[trel_label(sym_t'(s), sym_t'(u))];
        if (cand > best) begin       // Strict, lower index keeps a tie
          best = cand;
          sel  = sym_t'(s);
        end
      end
      // Old state 0 as reference keeps the spread inside cPM_W
      pm_new[u]  = best - pm_pred[0];
      dec_new[u] = sel;
    end
  end

  //----------------------------------------------------------
  // Registers
  //----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= ival;
    end
  end

  // Metrics hold between beats and across gaps
  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      osop <= isop;
      oeop <= ieop;
      otag <= itag;
      odec <= dec_new;
      for (int u = 0; u < cSTATE_NUM; u++) begin
        opm[u] <= pm_new[u];
      end
    end
  end

endmodule

// ==== common/vit_3by4_pkg.sv ====
// Shared trellis types for the rate 3/4 decoder; llr_t is fixed at cLLR_W bits, tag_t at 4 bits
package vit_3by4_pkg;

  //----------------------------------------------------------
  // Trellis and datapath sizes
  //----------------------------------------------------------

  localparam int cSTATE_NUM = 8;   // State is the previous input symbol
  localparam int cBM_NUM    = 16;  // All 4-bit branch labels
  localparam int cLLR_W     = 4;   // Default soft width
  localparam int cPM_W      = 10;  // Path metric width, normalized each step

  //----------------------------------------------------------
  // Types
  //----------------------------------------------------------

  typedef logic signed [cLLR_W-1:0] llr_t;        // Positive means bit 1
  typedef logic        [3:0]        boutputs_t;   // One branch label
  typedef logic        [2:0]        sym_t;        // Input symbol, doubles as state
  typedef logic        [3:0]        tag_t;

  // Sum of four LLRs needs 2 extra bits, one more for headroom
  typedef logic signed [cLLR_W+2:0] trel_bm_t;
  typedef trel_bm_t                 bm_t [cBM_NUM];

  typedef logic signed [cPM_W-1:0]  pm_t;

  // Survivor predecessor for every state, index is the next state
  typedef sym_t [cSTATE_NUM-1:0]    dec_t;

  typedef enum logic [1:0] {
    TB_IDLE,    // Wait for end of frame
    TB_SEARCH,  // Best final state
    TB_TRACE,   // Walk back through decisions
    TB_OUT      // Last symbol out, drop busy
  } tb_state_e;

  //----------------------------------------------------------
  // Branch label for the transition s -> u
  //----------------------------------------------------------

  function automatic boutputs_t trel_label(input sym_t s, input sym_t u);
    boutputs_t lab;
    lab[0] = u[0] ^ s[0];
    lab[1] = u[1] ^ s[1];
    lab[2] = u[2] ^ s[2];
    lab[3] = u[0] ^ u[1] ^ u[2] ^ s[0];  // Parity ties in the previous bit 0
    return lab;
  endfunction

endpackage

// ==== compile.f ====
common/vit_3by4_pkg.sv
src/vit_3by4_dec_bmc.sv
acs/vit_3by4_dec_acs.sv
traceback/vit_3by4_dec_traceback.sv
src/vit_3by4_dec.sv
dv/vit_3by4_dec_checker.sv
dv/vit_3by4_dec_tb.sv

// ==== dv/vit_3by4_dec_checker.sv ====
// Stream protocol assertions bound into the decoder top; the input side must respect obusy
`timescale 1ns/1ns

module vit_3by4_dec_checker (
  input logic iclk,
  input logic ireset,
  input logic iclkena,
  input logic isop,
  input logic ival,
  input logic osop,
  input logic oval,
  input logic oeop,
  input logic obusy
);

  int fail_count = 0;   // Number of failed assertions

  // Output stream stays quiet while in reset
  a_reset_quiet : assert property (@(posedge iclk) ireset |-> !oval)
    else begin
      fail_count++;
      $error("oval high during reset");
    end

  a_flags_with_val : assert property (@(posedge iclk) disable iff (ireset)
    (osop || oeop) |-> oval)
    else begin
      fail_count++;
      $error("osop or oeop without oval");
    end

  // One frame at a time inside the traceback
  a_no_sop_when_busy : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && ival && isop) |-> !obusy)
    else begin
      fail_count++;
      $error("frame start while obusy is high");
    end

  a_busy_until_eop : assert property (@(posedge iclk) disable iff (ireset)
    $fell(obusy) |-> $past(oeop))
    else begin
      fail_count++;
      $error("obusy dropped before the last symbol");
    end

endmodule

bind vit_3by4_dec vit_3by4_dec_checker checker_inst (
  .iclk    (iclk),
  .ireset  (ireset),
  .iclkena (iclkena),
  .isop    (isop),
  .ival    (ival),
  .osop    (osop),
  .oval    (oval),
  .oeop    (oeop),
  .obusy   (obusy)
);

// ==== dv/vit_3by4_dec_tb.sv ====
// Directed decoder tests with a behavioral encoder; runs with default 4-bit LLRs and pMAX_LEN 32
`timescale 1ns/1ns

module vit_3by4_dec_tb;
  import vit_3by4_pkg::*;

  localparam int cCLK_PERIOD = 100;
  localparam int cMAX_LEN    = 32;
  localparam int pA          = 6;                       // Clean LLR magnitude
  localparam int cLLR_MAX    = (1 << (cLLR_W-1)) - 1;
  localparam int cLLR_MIN    = -(1 << (cLLR_W-1));     // Code that the BMC saturates
  localparam int cMODE_CLEAN = 0;
  localparam int cMODE_SAT   = 1;
  localparam int cMODE_NOISE = 2;
  localparam int cMODE_ZERO  = 3;
  // Every frame plus 10 cycles of pipeline and traceback
  localparam int cFRAME_CYCLES = (8+10) + (8+10) + (16+10) + (1+10) + (cMAX_LEN+10) + (4+10);
  localparam int cWATCHDOG_NS  = (2*cFRAME_CYCLES + 8 + 200) * cCLK_PERIOD;

  logic iclk, ireset, iclkena;
  logic isop, ival, ieop;
  tag_t itag;
  llr_t iLLR [4];
  logic osop, oval, oeop, obusy;
  tag_t otag;
  sym_t osym;

  int          errors = 0;
  int          tests  = 0;
  int          failed = 0;
  int unsigned lcg_state = 86;
  logic        gap_en   = 1'b0;    // Random iclkena low cycles
  logic        ena_prev = 1'b0;    // iclkena at the last rising edge
  sym_t        exp_sym [$];        // Sent symbols in frame order
  sym_t        out_sym [$];
  tag_t        out_tag [$];
  logic        out_sop [$];
  logic        out_eop [$];
  logic        out_busy [$];       // obusy seen with each symbol

  vit_3by4_dec #(
    .pLLR_W   (cLLR_W),
    .pTAG_W   (4),
    .pMAX_LEN (cMAX_LEN)
  ) vit_3by4_dec_inst (
    .iclk    (iclk),    .ireset (ireset),  .iclkena (iclkena),
    .isop    (isop),    .ival   (ival),    .ieop    (ieop),
    .itag    (itag),    .iLLR   (iLLR),
    .osop    (osop),    .oval   (oval),    .oeop    (oeop),
    .otag    (otag),    .osym   (osym),    .obusy   (obusy)
  );

  //------------------------------------------------------------
  // Clock, watchdog and output monitor
  //------------------------------------------------------------

  initial begin
    iclk = 1'b0;
    forever #(cCLK_PERIOD/2) iclk = ~iclk;
  end

  initial begin
    #(cWATCHDOG_NS);
    $display("timeout: the run took longer than its frames allow");
    $display("Finished with errors");
    $finish;
  end

  always @(posedge iclk) begin
    ena_prev <= iclkena;
  end

  // Outputs hold through frozen cycles, so a new beat needs an enabled edge
  always @(negedge iclk) begin
    if (ena_prev && oval) begin
      out_sym.push_back(osym);
      out_tag.push_back(otag);
      out_sop.push_back(osop);
      out_eop.push_back(oeop);
      out_busy.push_back(obusy);
    end
  end

  //------------------------------------------------------------
  // Stimulus helpers
  //------------------------------------------------------------

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;               // Upper bits are the better ones
  endfunction

  task automatic next_cycle();
    @(negedge iclk);
    iclkena = gap_en ? ((lcg_next() % 4) != 0) : 1'b1;   // About one in four frozen
  endtask

  // Antipodal mapping of one code bit, flip gives a weak wrong sign
  function automatic llr_t soft_bit(input logic b, input int mode, input logic flip);
    int v;
    case (mode)
      cMODE_SAT  : v = b ? cLLR_MAX : cLLR_MIN;
      cMODE_ZERO : v = 0;
      default    : v = b ? pA : -pA;
    endcase
    if (flip) begin
      v = b ? -1 : 1;
    end
    return llr_t'(v);
  endfunction

  task automatic send_frame(input int len, input tag_t tag, input int mode);
    sym_t      s;
    sym_t      u;
    boutputs_t lab;
    int        flip_pos;
    s = '0;                               // Encoder starts in state 0
    exp_sym.delete();
    out_sym.delete();
    out_tag.delete();
    out_sop.delete();
    out_eop.delete();
    out_busy.delete();
    for (int k = 0; k < len; k++) begin
      u        = (mode == cMODE_ZERO) ? sym_t'(0) : sym_t'(lcg_next());
      lab      = trel_label(s, u);
      flip_pos = (mode == cMODE_NOISE) ? int'(lcg_next() % 4) : -1;
      do begin
        next_cycle();
      end while (!iclkena);
      ival = 1'b1;
      isop = (k == 0);
      ieop = (k == len - 1);
      itag = tag;
      for (int i = 0; i < 4; i++) begin
        iLLR[i] = soft_bit(lab[i], mode, i == flip_pos);
      end
      exp_sym.push_back(u);
      s = u;                              // Next state is the input symbol
    end
    next_cycle();
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
  endtask

  //------------------------------------------------------------
  // Compare tasks and frame check
  //------------------------------------------------------------

  task automatic cmp_sym(input sym_t got, input sym_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_tag(input tag_t got, input tag_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_frame(input int len, input tag_t tag);
    int wait_cnt;
    wait_cnt = 0;
    while (out_sym.size() < len && wait_cnt < (len + 10) * 4) begin
      next_cycle();
      wait_cnt++;
    end
    wait_cnt = 0;
    while (obusy && wait_cnt < 20) begin  // Busy drops one enabled cycle after oeop
      next_cycle();
      wait_cnt++;
    end
    if (obusy) begin
      $display("%0t: obusy is still high after the frame", $time);
      errors++;
    end
    repeat (3) next_cycle();              // Catches a stray extra symbol
    if (out_sym.size() != len) begin
      $display("%0t: got %0d output symbols instead of %0d", $time, out_sym.size(), len);
      errors++;
    end
    for (int i = 0; i < len && i < out_sym.size(); i++) begin
      cmp_sym(out_sym[i], exp_sym[len-1-i], $sformatf("symbol %0d", i));   // Last step first
      cmp_tag(out_tag[i], tag, $sformatf("tag of symbol %0d", i));
      cmp_flag(out_sop[i], i == 0, $sformatf("osop of symbol %0d", i));
      cmp_flag(out_eop[i], i == len - 1, $sformatf("oeop of symbol %0d", i));
      cmp_flag(out_busy[i], 1'b1, $sformatf("obusy with symbol %0d", i));
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  //------------------------------------------------------------
  // Directed tests
  //------------------------------------------------------------

  task automatic decode_clean_frame();
    int err_before;
    err_before = errors;
    send_frame(8, tag_t'(4'h3), cMODE_CLEAN);
    check_frame(8, tag_t'(4'h3));
    report_test("clean frame", err_before);
  endtask

  task automatic decode_saturated_frame();
    int err_before;
    err_before = errors;
    send_frame(8, tag_t'(4'h9), cMODE_SAT);
    check_frame(8, tag_t'(4'h9));
    report_test("saturated LLRs", err_before);
  endtask

  task automatic correct_noisy_frame();
    int err_before;
    err_before = errors;
    send_frame(16, tag_t'(4'h6), cMODE_NOISE);
    check_frame(16, tag_t'(4'h6));
    report_test("correctable noise", err_before);
  endtask

  task automatic pass_frames_with_gaps();
    int err_before;
    err_before = errors;
    gap_en = 1'b1;
    send_frame(1, tag_t'(4'h5), cMODE_CLEAN);
    check_frame(1, tag_t'(4'h5));         // Returns once obusy is low
    send_frame(cMAX_LEN, tag_t'(4'hA), cMODE_CLEAN);
    check_frame(cMAX_LEN, tag_t'(4'hA));
    gap_en = 1'b0;
    next_cycle();                         // Leaves iclkena high
    report_test("frames with iclkena gaps", err_before);
  endtask

  task automatic resolve_ties();
    int err_before;
    err_before = errors;
    send_frame(4, tag_t'(4'hC), cMODE_ZERO);
    check_frame(4, tag_t'(4'hC));
    report_test("all metrics tied", err_before);
  endtask

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------

  initial begin
    ireset  = 1'b1;
    iclkena = 1'b1;
    isop    = 1'b0;
    ival    = 1'b0;
    ieop    = 1'b0;
    itag    = '0;
    for (int i = 0; i < 4; i++) begin
      iLLR[i] = '0;
    end
    repeat (8) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;

    decode_clean_frame();
    decode_saturated_frame();
    correct_noisy_frame();
    pass_frames_with_gaps();
    resolve_ties();

    errors += vit_3by4_dec_inst.checker_inst.fail_count;   // Bound assertion failures
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== src/vit_3by4_dec.sv ====
// Rate 3/4 block Viterbi decoder, output symbols come last step first; no new frame while obusy
`timescale 1ns/1ns

module vit_3by4_dec
  import vit_3by4_pkg::*;
#(
  parameter int pLLR_W   = cLLR_W,
  parameter int pTAG_W   = 4,       // Tag width is fixed by tag_t
  parameter int pMAX_LEN = 32
)
(
  input  logic iclk,
  input  logic ireset,
  input  logic iclkena,      // Low freezes the whole pipeline
  //
  input  logic isop,
  input  logic ival,
  input  logic ieop,
  input  tag_t itag,
  input  llr_t iLLR [4],
  //
  output logic osop,
  output logic oval,
  output logic oeop,
  output tag_t otag,
  output sym_t osym,
  output logic obusy
);

  if (pTAG_W != $bits(tag_t)) begin : g_tag_w_check
    $error("pTAG_W does not match tag_t width");
  end

  //----------------------------------------------------------
  // Stage streams
  //----------------------------------------------------------

  logic bmc_sop, bmc_val, bmc_eop;
  tag_t bmc_tag;
  bm_t  bmc_bm;

  logic acs_sop, acs_val, acs_eop;
  tag_t acs_tag;
  dec_t acs_dec;
  pm_t  acs_pm [cSTATE_NUM];

  vit_3by4_dec_bmc #(
    .pLLR_W (pLLR_W)
  ) bmc_inst (
    .iclk    (iclk),     .ireset (ireset),   .iclkena (iclkena),
    .isop    (isop),     .ival   (ival),     .ieop    (ieop),
    .itag    (itag),     .iLLR   (iLLR),
    .osop    (bmc_sop),  .oval   (bmc_val),  .oeop    (bmc_eop),
    .otag    (bmc_tag),  .obm    (bmc_bm)
  );

  vit_3by4_dec_acs acs_inst (
    .iclk    (iclk),     .ireset (ireset),   .iclkena (iclkena),
    .isop    (bmc_sop),  .ival   (bmc_val),  .ieop    (bmc_eop),
    .itag    (bmc_tag),  .ibm    (bmc_bm),
    .osop    (acs_sop),  .oval   (acs_val),  .oeop    (acs_eop),
    .otag    (acs_tag),  .odec   (acs_dec),  .opm     (acs_pm)
  );

  vit_3by4_dec_traceback #(
    .pMAX_LEN (pMAX_LEN)
  ) traceback_inst (
    .iclk    (iclk),     .ireset (ireset),   .iclkena (iclkena),
    .isop    (acs_sop),  .ival   (acs_val),  .ieop    (acs_eop),
    .itag    (acs_tag),  .idec   (acs_dec),  .ipm     (acs_pm),
    .osop    (osop),     .oval   (oval),     .oeop    (oeop),
    .otag    (otag),     .osym   (osym),     .obusy   (obusy)
  );

endmodule

// ==== src/vit_3by4_dec_bmc.sv ====
// Branch metrics, pLLR_W must equal the package LLR width; one registered beat per input beat
`timescale 1ns/1ns

module vit_3by4_dec_bmc
  import vit_3by4_pkg::*;
#(
  parameter int pLLR_W = cLLR_W
)
(
  input  logic iclk,
  input  logic ireset,
  input  logic iclkena,
  //
  input  logic isop,
  input  logic ival,
  input  logic ieop,
  input  tag_t itag,
  input  llr_t iLLR [4],   // Soft bits, positive is 1
  //
  output logic osop,
  output logic oval,
  output logic oeop,
  output tag_t otag,
  output bm_t  obm
);

  //----------------------------------------------------------
  // Saturation of the most negative code
  //----------------------------------------------------------

  localparam llr_t cLLR_MIN = llr_t'({1'b1, {(pLLR_W-1){1'b0}}});             // -2^(N-1)
  localparam llr_t cLLR_SAT = llr_t'({1'b1, {(pLLR_W-2){1'b0}}, 1'b1});      // -(2^(N-1)-1)

  if (pLLR_W != $bits(llr_t)) begin : g_llr_w_check
    $error("pLLR_W does not match llr_t width");
  end

  llr_t llr_sat [4];

  // Keeps +/- symmetric so a strong 0 never outweighs a strong 1
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      llr_sat[i] = (iLLR[i] == cLLR_MIN) ? cLLR_SAT : iLLR[i];
    end
  end

  //----------------------------------------------------------
  // Output stream
  //----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      osop <= isop;
      oeop <= ieop;
      otag <= itag;
      for (int b = 0; b < cBM_NUM; b++) begin
        obm[b] <= label_metric(llr_sat, boutputs_t'(b));  // Label b metric
      end
    end
  end

  // Correlation of a label with the soft bits
  function automatic trel_bm_t label_metric(input llr_t llr [4], input boutputs_t lab);
    trel_bm_t acc;
    acc = '0;
    for (int i = 0; i < 4; i++) begin
      acc = lab[i] ? (acc + llr[i]) : (acc - llr[i]);
    end
    return acc;
  endfunction

endmodule

// ==== traceback/vit_3by4_dec_traceback.sv ====
// Block traceback, one frame at a time of up to pMAX_LEN steps; next frame only after obusy falls
`timescale 1ns/1ns

module vit_3by4_dec_traceback
  import vit_3by4_pkg::*;
#(
  parameter int pMAX_LEN = 32
)
(
  input  logic iclk,
  input  logic ireset,
  input  logic iclkena,
  //
  input  logic isop,
  input  logic ival,
  input  logic ieop,
  input  tag_t itag,
  input  dec_t idec,
  input  pm_t  ipm [cSTATE_NUM],   // Only read on the eop beat
  //
  output logic osop,               // Last trellis step
  output logic oval,
  output logic oeop,               // First trellis step
  output tag_t otag,
  output sym_t osym,
  output logic obusy
);

  localparam int cADDR_W = (pMAX_LEN > 1) ? $clog2(pMAX_LEN) : 1;

  //----------------------------------------------------------
  // Decision memory
  //----------------------------------------------------------

  dec_t dec_mem [pMAX_LEN];

  logic [cADDR_W-1:0] waddr;       // Next write slot within the frame
  logic [cADDR_W-1:0] wr_addr;
  logic [cADDR_W-1:0] last_addr;   // Step index of the eop beat
  logic [cADDR_W-1:0] rd_addr;

  tb_state_e state;
  pm_t       pm_lat [cSTATE_NUM];
  sym_t      cur_state;
  sym_t      best_state;
  pm_t       best_pm;
  logic      eop_beat;

  assign wr_addr  = isop ? '0 : waddr;              // Frame restarts at slot 0
  assign eop_beat = ival && ieop && (state == TB_IDLE);

  //----------------------------------------------------------
  // Best final state
  //----------------------------------------------------------

  always_comb begin
    best_pm    = pm_lat[0];
    best_state = '0;
    for (int s = 1; s < cSTATE_NUM; s++) begin
      if (pm_lat[s] > best_pm) begin   // Lowest index wins a tie
        best_pm    = pm_lat[s];
        best_state = sym_t'(s);
      end
    end
  end

  //----------------------------------------------------------
  // Control FSM and framing
  //----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= TB_IDLE;
      waddr <= '0;
      obusy <= 1'b0;
      oval  <= 1'b0;
      osop  <= 1'b0;
      oeop  <= 1'b0;
    end else if (iclkena) begin
      if (ival) begin
        waddr <= wr_addr + 1'b1;
      end
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
      case (state)
        TB_IDLE : begin
          if (eop_beat) begin
            obusy <= 1'b1;
            state <= TB_SEARCH;
          end
        end
        TB_SEARCH : begin                  // Emits the best state itself
          oval  <= 1'b1;
          osop  <= 1'b1;
          oeop  <= (last_addr == '0);      // One step frame
          state <= (last_addr == '0) ? TB_OUT : TB_TRACE;
        end
        TB_TRACE : begin
          oval <= 1'b1;
          oeop <= (rd_addr == '0);
          if (rd_addr == '0) begin
            state <= TB_OUT;
          end
        end
        default : begin                    // TB_OUT, oeop is on the port now
          obusy <= 1'b0;
          state <= TB_IDLE;
        end
      endcase
    end
  end

  //----------------------------------------------------------
  // Datapath
  //----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (ival) begin
        dec_mem[wr_addr] <= idec;
      end
      if (eop_beat) begin
        last_addr <= wr_addr;
        otag      <= itag;                 // Held for the whole output frame
        for (int s = 0; s < cSTATE_NUM; s++) begin
          pm_lat[s] <= ipm[s];
        end
      end
      if (state == TB_SEARCH) begin
        osym      <= best_state;
        cur_state <= dec_mem[last_addr][best_state];
        rd_addr   <= last_addr - 1'b1;
      end
      if (state == TB_TRACE) begin
        osym      <= cur_state;
        cur_state <= dec_mem[rd_addr][cur_state];  // Step back one symbol
        rd_addr   <= rd_addr - 1'b1;
      end
    end
  end

endmodule
